//--- boot_block.sv
`timescale 1ns/10ps
`default_nettype none

module boot_block (
    input  logic       i_clk,
    input  logic       i_rst_n,

    // Write requests toward the memory controller.
    mem_bus_if.master  mem,

    // Byte transfers through the storage controller.
    spi_xfer_if.master spi,

    // High once the whole image sits in SRAM.
    output logic       o_is_booted
);

    import mem_pkg::*;
    import spi_pkg::*;

    boot_state_e state_q;
    boot_state_e byte_next;
    logic        wait_q;
    boot_cnt_t   word_cnt_q;
    mem_data_t   word_q;
    logic        booted_q;
    logic        last_word;
    logic        byte_state;
    logic        tx_fire;
    logic        rx_done;
    spi_byte_t   tx_byte;

    // ------------------------------
    // Byte sequencing
    // ------------------------------

    // States that move one SPI byte each.
    assign byte_state = state_q inside {BOOT_CMD, BOOT_ADDR_HI, BOOT_ADDR_LO,
                                        BOOT_READ_HI, BOOT_READ_LO};
    assign last_word  = (word_cnt_q == boot_cnt_t'(BOOT_WORDS - 1));
    assign tx_fire    = spi.tx_valid && spi.tx_ready;
    assign rx_done    = wait_q && spi.rx_valid;

    // Byte to send in each state, and where to go once it is back.
    always_comb begin
        tx_byte   = SPI_DUMMY_BYTE;
        byte_next = state_q;
        case (state_q)
            BOOT_CMD: begin
                tx_byte   = SPI_CMD_READ;
                byte_next = BOOT_ADDR_HI;
            end
            BOOT_ADDR_HI: begin
                tx_byte   = BOOT_SRC_ADDR[15:8];
                byte_next = BOOT_ADDR_LO;
            end
            BOOT_ADDR_LO: begin
                tx_byte   = BOOT_SRC_ADDR[7:0];
                byte_next = BOOT_READ_HI;
            end
            BOOT_READ_HI: byte_next = BOOT_READ_LO;
            BOOT_READ_LO: byte_next = BOOT_WRITE;
            default:      byte_next = state_q;
        endcase
    end

    // Offer a byte only while not waiting on the previous one.
    assign spi.tx_valid = byte_state && !wait_q;
    assign spi.tx_byte  = tx_byte;

    // One chip-select period, closed by the last data byte.
    assign spi.hold_cs  = !((state_q == BOOT_READ_LO) && last_word);

    // Image word n is written to BOOT_BASE + n.
    assign mem.req_valid = (state_q == BOOT_WRITE);
    assign mem.req_wr    = 1'b1;
    assign mem.req_addr  = BOOT_BASE + mem_addr_t'(word_cnt_q);
    assign mem.req_wdata = word_q;

    assign o_is_booted = booted_q;

    // ------------------------------
    // Control state
    // ------------------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= BOOT_IDLE;
            wait_q     <= 1'b0;
            word_cnt_q <= '0;
            booted_q   <= 1'b0;
        end else begin
            case (state_q)
                BOOT_IDLE: state_q <= BOOT_CMD;
                BOOT_WRITE: begin
                    // Hold the request until the arbiter takes it.
                    if (mem.req_ready) begin
                        if (last_word) begin
                            state_q  <= BOOT_DONE;
                            booted_q <= 1'b1;
                        end else begin
                            word_cnt_q <= word_cnt_q + boot_cnt_t'(1);
                            state_q    <= BOOT_READ_HI;
                        end
                    end
                end
                BOOT_DONE: state_q <= BOOT_DONE;
                default: begin
                    // Byte states send, then wait for the read-back.
                    if (tx_fire) begin
                        wait_q <= 1'b1;
                    end else if (rx_done) begin
                        wait_q  <= 1'b0;
                        state_q <= byte_next;
                    end
                end
            endcase
        end
    end

    // Word assembly, high byte first.
    always_ff @(posedge i_clk) begin
        if (rx_done && (state_q == BOOT_READ_HI)) begin
            word_q[15:8] <= spi.rx_byte;
        end
        if (rx_done && (state_q == BOOT_READ_LO)) begin
            word_q[7:0] <= spi.rx_byte;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
mem_pkg.sv
spi_pkg.sv
mem_bus_if.sv
spi_xfer_if.sv
boot_block.sv
storage_ctrl.sv
memory_ctrl.sv
uproc.sv
uproc_properties.sv
tb_uproc.sv

//--- mem_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if;

    import mem_pkg::*;

    // Handshake. A request moves on an edge with both high.
    logic      req_valid;
    logic      req_ready;

    // Request fields, steady while valid waits on ready.
    logic      req_wr;
    mem_addr_t req_addr;
    mem_data_t req_wdata;

    // Requester side.
    modport master (
        output req_valid,
        input  req_ready,
        output req_wr,
        output req_addr,
        output req_wdata
    );

    // Arbiter side, which grants by driving ready.
    modport arbiter (
        input  req_valid,
        output req_ready,
        input  req_wr,
        input  req_addr,
        input  req_wdata
    );

endinterface

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

    // ------------------------------
    // SRAM bus
    // ------------------------------

    // Word address and data widths of the external SRAM.
    localparam int MEM_ADDR_W = 16;
    localparam int MEM_DATA_W = 16;

    // One SRAM word address.
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // One SRAM data word.
    typedef logic [MEM_DATA_W-1:0] mem_data_t;

    // ------------------------------
    // Boot image layout
    // ------------------------------

    // Words copied out of the EEPROM at boot.
    localparam int BOOT_WORDS = 32;

    // Index of one image word, 0 to BOOT_WORDS-1.
    localparam int BOOT_CNT_W = $clog2(BOOT_WORDS);
    typedef logic [BOOT_CNT_W-1:0] boot_cnt_t;

    // First SRAM word that receives the image.
    localparam mem_addr_t BOOT_BASE = 16'h0100;

endpackage

`default_nettype wire

//--- memory_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module memory_ctrl (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_is_booted,

    // Requesters. Boot owns the bus before boot, host after.
    mem_bus_if.arbiter         boot,
    mem_bus_if.arbiter         host,

    // SRAM pins.
    output mem_pkg::mem_addr_t o_mem_addr,
    output mem_pkg::mem_data_t o_mem_wdata,
    input  mem_pkg::mem_data_t i_mem_rdata,
    output logic               o_mem_wr,
    output logic               o_mem_en,

    // Read return to the host.
    output mem_pkg::mem_data_t o_host_rdata,
    output logic               o_host_rvalid
);

    import mem_pkg::*;

    logic      boot_fire;
    logic      host_fire;
    logic      sel_fire;
    logic      sel_wr;
    mem_addr_t sel_addr;
    mem_data_t sel_wdata;
    logic      en_q;
    logic      wr_q;
    logic      rd_pend_q;
    logic      rvalid_q;
    mem_addr_t addr_q;
    mem_data_t wdata_q;
    mem_data_t rdata_q;

    // ------------------------------
    // Ownership
    // ------------------------------

    // Only one side is ever ready.
    assign boot.req_ready = !i_is_booted;
    assign host.req_ready = i_is_booted;

    assign boot_fire = boot.req_valid && boot.req_ready;
    assign host_fire = host.req_valid && host.req_ready;
    assign sel_fire  = boot_fire || host_fire;

    assign sel_wr    = i_is_booted ? host.req_wr    : boot.req_wr;
    assign sel_addr  = i_is_booted ? host.req_addr  : boot.req_addr;
    assign sel_wdata = i_is_booted ? host.req_wdata : boot.req_wdata;

    // ------------------------------
    // Bus and read pipeline
    // ------------------------------

    // Stage 1 drives the bus, stage 2 returns host read data.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            en_q      <= 1'b0;
            wr_q      <= 1'b0;
            rd_pend_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            en_q      <= sel_fire;
            wr_q      <= sel_fire && sel_wr;
            rd_pend_q <= host_fire && !host.req_wr;
            rvalid_q  <= rd_pend_q;
        end
    end

    // SRAM reads combinationally, so capture while the address is up.
    always_ff @(posedge i_clk) begin
        if (sel_fire) begin
            addr_q  <= sel_addr;
            wdata_q <= sel_wdata;
        end
        if (rd_pend_q) begin
            rdata_q <= i_mem_rdata;
        end
    end

    assign o_mem_addr    = addr_q;
    assign o_mem_wdata   = wdata_q;
    assign o_mem_wr      = wr_q;
    assign o_mem_en      = en_q;
    assign o_host_rdata  = rdata_q;
    assign o_host_rvalid = rvalid_q;

endmodule

`default_nettype wire

//--- spi_pkg.sv
`default_nettype none

package spi_pkg;

    // ------------------------------
    // SPI bytes and EEPROM access
    // ------------------------------

    // One byte on the SPI wires.
    typedef logic [7:0] spi_byte_t;

    // Byte address inside the EEPROM.
    typedef logic [15:0] store_addr_t;

    // Standard EEPROM read command, and where the image starts.
    localparam spi_byte_t   SPI_CMD_READ   = 8'h03;
    localparam store_addr_t BOOT_SRC_ADDR  = 16'h0000;

    // Sent while clocking read data back; the EEPROM ignores it.
    localparam spi_byte_t   SPI_DUMMY_BYTE = 8'h00;

    // SCK edges per byte, and a counter that covers them.
    localparam int SPI_TOGGLES = 16;
    typedef logic [$clog2(SPI_TOGGLES)-1:0] spi_cnt_t;

    // ------------------------------
    // State machines
    // ------------------------------

    typedef enum logic [2:0] {
        BOOT_IDLE, BOOT_CMD, BOOT_ADDR_HI, BOOT_ADDR_LO,
        BOOT_READ_HI, BOOT_READ_LO, BOOT_WRITE, BOOT_DONE
    } boot_state_e;

    typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_FINISH} spi_state_e;

endpackage

`default_nettype wire

//--- spi_xfer_if.sv
`timescale 1ns/10ps
`default_nettype none

interface spi_xfer_if;

    import spi_pkg::*;

    // Transmit side. A byte is taken when valid and ready are both high.
    logic      tx_valid;
    logic      tx_ready;
    spi_byte_t tx_byte;

    // Keep chip select low after the current byte.
    logic      hold_cs;

    // One-cycle pulse with the byte read back.
    logic      rx_valid;
    spi_byte_t rx_byte;

    // Byte source, the boot block here.
    modport master (
        output tx_valid,
        input  tx_ready,
        output tx_byte,
        output hold_cs,
        input  rx_valid,
        input  rx_byte
    );

    // Shift engine side.
    modport slave (
        input  tx_valid,
        output tx_ready,
        input  tx_byte,
        input  hold_cs,
        output rx_valid,
        output rx_byte
    );

endinterface

`default_nettype wire

//--- storage_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module storage_ctrl (
    input  logic      i_clk,
    input  logic      i_rst_n,

    // Byte requests from the boot block.
    spi_xfer_if.slave spi,

    // EEPROM pins, SPI mode 0.
    output logic      o_sck,
    output logic      o_sdi,
    input  logic      i_sdo,
    output logic      o_scs_n
);

    import spi_pkg::*;

    spi_state_e state_q;
    spi_cnt_t   cnt_q;
    spi_byte_t  shift_q;
    logic       sck_q;
    logic       sdi_q;
    logic       scs_n_q;
    logic       tx_fire;
    logic       last_toggle;

    // ------------------------------
    // Handshake
    // ------------------------------

    // Busy only while shifting, so FINISH can take the next byte.
    assign spi.tx_ready = (state_q != SPI_SHIFT);
    assign spi.rx_valid = (state_q == SPI_FINISH);
    assign spi.rx_byte  = shift_q;

    assign tx_fire     = spi.tx_valid && spi.tx_ready;
    assign last_toggle = (cnt_q == spi_cnt_t'(SPI_TOGGLES - 1));

    assign o_sck   = sck_q;
    assign o_sdi   = sdi_q;
    assign o_scs_n = scs_n_q;

    // ------------------------------
    // Shift engine
    // ------------------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= SPI_IDLE;
            cnt_q   <= '0;
            sck_q   <= 1'b0;
            sdi_q   <= 1'b0;
            scs_n_q <= 1'b1;
        end else begin
            case (state_q)
                SPI_SHIFT: begin
                    // SCK toggles every clock.
                    sck_q <= !sck_q;
                    cnt_q <= cnt_q + spi_cnt_t'(1);
                    // Next bit goes out on the falling edge
                    if (sck_q && !last_toggle) begin
                        sdi_q <= shift_q[7];
                    end
                    if (last_toggle) begin
                        state_q <= SPI_FINISH;
                        // Chip select opens only at the end of a byte.
                        if (!spi.hold_cs) begin
                            scs_n_q <= 1'b1;
                        end
                    end
                end
                default: begin
                    // Ready for a byte when idle or finishing.
                    if (tx_fire) begin
                        state_q <= SPI_SHIFT;
                        cnt_q   <= '0;
                        scs_n_q <= 1'b0;
                        sdi_q   <= spi.tx_byte[7];
                    end else begin
                        state_q <= SPI_IDLE;
                    end
                end
            endcase
        end
    end

    // Full duplex. SDO shifts in at each rising SCK.
    always_ff @(posedge i_clk) begin
        if (tx_fire) begin
            shift_q <= spi.tx_byte;
        end else if ((state_q == SPI_SHIFT) && !sck_q) begin
            shift_q <= {shift_q[6:0], i_sdo};
        end
    end

endmodule

`default_nettype wire

//--- tb_uproc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_uproc;

    import mem_pkg::*;
    import spi_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h3658_3d73;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int          RAND_TXNS = 200;
    localparam int          HOST_TXNS = RAND_TXNS + 2;
    localparam mem_addr_t   HELD_ADDR = 16'h2000;
    localparam mem_addr_t   RAND_BASE = 16'h4000;
    // Roughly 20 cycles per SPI byte, 4 per host transaction, doubled.
    localparam int WATCHDOG_CYCLES = 2 * ((3 + 2 * BOOT_WORDS) * 20 + 4 * HOST_TXNS) + 200;

    // DUT ports.
    logic      i_clk = 1'b0;
    logic      i_rst_n = 1'b0;
    mem_addr_t o_mem_addr;
    mem_data_t o_mem_wdata;
    mem_data_t i_mem_rdata;
    logic      o_mem_wr;
    logic      o_mem_en;
    logic      o_store_sck;
    logic      o_store_sdi;
    logic      i_store_sdo = 1'b0;
    logic      o_store_scs_n;
    logic      i_host_valid = 1'b0;
    logic      o_host_ready;
    logic      i_host_wr = 1'b0;
    mem_addr_t i_host_addr = '0;
    mem_data_t i_host_wdata = '0;
    mem_data_t o_host_rdata;
    logic      o_host_rvalid;
    logic      o_is_booted;

    // Bench state.
    logic [31:0] lfsr_q;
    int          cycle_cnt = 0;
    int          error_count = 0;
    int          test_base = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          held_cycles = 0;
    int          ready_early = 0;
    int          spi_after_boot = 0;
    int          boot_writes = 0;
    int          bad_boot_addr = 0;
    logic        owner_host_q = 1'b0;
    mem_data_t   sram [0:65535];
    mem_data_t   exp_mem [0:65535];
    mem_data_t   exp_rd_data [$];
    int          exp_rd_cycle [$];

    // EEPROM model state.
    spi_byte_t   eeprom_img [0:255];
    int          ee_bits = 0;
    int          cs_periods = 0;
    logic [23:0] ee_hdr = '0;
    spi_byte_t   first_bytes [$];

    uproc i_uproc (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wdata   (o_mem_wdata),
        .i_mem_rdata   (i_mem_rdata),
        .o_mem_wr      (o_mem_wr),
        .o_mem_en      (o_mem_en),
        .o_store_sck   (o_store_sck),
        .o_store_sdi   (o_store_sdi),
        .i_store_sdo   (i_store_sdo),
        .o_store_scs_n (o_store_scs_n),
        .i_host_valid  (i_host_valid),
        .o_host_ready  (o_host_ready),
        .i_host_wr     (i_host_wr),
        .i_host_addr   (i_host_addr),
        .i_host_wdata  (i_host_wdata),
        .o_host_rdata  (o_host_rdata),
        .o_host_rvalid (o_host_rvalid),
        .o_is_booted   (o_is_booted)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    // Power-up SRAM contents depend on every address bit.
    function automatic mem_data_t fill_word(input mem_addr_t a);
        return {a[7:0], a[15:8]} ^ 16'h5a3c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got) begin
            error_count++;
            $display("Mismatch %s exp %h got %h", name, exp, got);
        end
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (error_count != test_base) begin
            tests_bad++;
            $display("[%0d] %s: FAIL, %0d errors", num, name, error_count - test_base);
        end else begin
            $display("[%0d] %s: pass", num, name);
        end
        test_base = error_count;
    endtask

    // Called at a rising edge; returns at the rising edge where the next request may start.
    task automatic host_request(input logic wr, input mem_addr_t addr,
                                input mem_data_t wdata, input int gap);
        i_host_valid <= 1'b1;
        i_host_wr    <= wr;
        i_host_addr  <= addr;
        i_host_wdata <= wdata;
        held_cycles = 0;
        @(negedge i_clk);
        while (o_host_ready !== 1'b1) begin
            held_cycles++;
            @(negedge i_clk);
        end
        // Taken on the coming edge.
        if (wr) begin
            exp_mem[addr] = wdata;
        end else begin
            exp_rd_data.push_back(exp_mem[addr]);
            exp_rd_cycle.push_back(cycle_cnt + 2);
        end
        @(posedge i_clk);
        if (gap > 0) begin
            i_host_valid <= 1'b0;
            repeat (gap) @(posedge i_clk);
        end
    endtask

    task automatic wait_reads_done();
        while (exp_rd_data.size() != 0) begin
            @(negedge i_clk);
        end
    endtask

    // ------------------------------
    // Memory models and monitors
    // ------------------------------

    // Asynchronous SRAM read and a write on each enabled edge.
    assign i_mem_rdata = sram[o_mem_addr];

    always @(posedge i_clk) begin
        if ((o_mem_en === 1'b1) && (o_mem_wr === 1'b1)) begin
            sram[o_mem_addr] <= o_mem_wdata;
            // Owner was the boot block if not booted at acceptance.
            if (owner_host_q !== 1'b1) begin
                boot_writes++;
                if ((o_mem_addr < BOOT_BASE) || (o_mem_addr >= BOOT_BASE + BOOT_WORDS)) begin
                    bad_boot_addr++;
                end
            end
        end
        owner_host_q <= o_is_booted;
    end

    // EEPROM slave. Header is command then address, data follows.
    always @(negedge o_store_scs_n) begin
        ee_bits = 0;
        cs_periods++;
    end

    always @(posedge o_store_sck) begin
        if (o_store_scs_n === 1'b0) begin
            if (ee_bits < 24) begin
                ee_hdr = {ee_hdr[22:0], o_store_sdi};
            end
            ee_bits++;
            if ((cs_periods == 1) && (ee_bits <= 24) && (ee_bits % 8 == 0)) begin
                first_bytes.push_back(ee_hdr[7:0]);
            end
        end
    end

    // Read data goes out on falling SCK, MSB first.
    always @(negedge o_store_sck) begin
        int idx;
        if ((o_store_scs_n === 1'b0) && (ee_bits >= 24)) begin
            idx = ee_bits - 24;
            i_store_sdo <= eeprom_img[8'(ee_hdr[15:0] + 16'(idx / 8))][7 - (idx % 8)];
        end
    end

    always @(negedge i_clk) begin
        if ((o_host_rvalid === 1'b1) && (exp_rd_data.size() == 0)) begin
            error_count++;
            $display("Host read data returned with no read outstanding");
        end else if (o_host_rvalid === 1'b1) begin
            check_value("o_host_rdata", exp_rd_data.pop_front(), o_host_rdata);
            check_value("read return cycle", exp_rd_cycle.pop_front(), cycle_cnt);
        end
        if (i_rst_n && (o_is_booted !== 1'b1) && (o_host_ready !== 1'b0)) begin
            ready_early++;
        end
        if ((o_is_booted === 1'b1) && ((o_store_scs_n !== 1'b1) || (o_store_sck !== 1'b0))) begin
            spi_after_boot++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        logic      wr_bit;
        mem_addr_t addr;
        mem_data_t data;
        mem_data_t held_data;
        int        gap;

        lfsr_q = LFSR_SEED;
        for (int a = 0; a < 65536; a++) begin
            sram[a]    = fill_word(mem_addr_t'(a));
            exp_mem[a] = sram[a];
        end
        for (int b = 0; b < 256; b++) begin
            eeprom_img[b] = spi_byte_t'(take_bits(8));
        end

        repeat (8) @(posedge i_clk);
        i_rst_n <= 1'b1;

        // Outputs idle in the first cycle out of reset.
        @(negedge i_clk);
        check_value("o_mem_en", 0, o_mem_en);
        check_value("o_mem_wr", 0, o_mem_wr);
        check_value("o_store_sck", 0, o_store_sck);
        check_value("o_store_scs_n", 1, o_store_scs_n);
        check_value("o_host_ready", 0, o_host_ready);
        check_value("o_host_rvalid", 0, o_host_rvalid);
        check_value("o_is_booted", 0, o_is_booted);
        finish_test(1, "reset values");

        // Host write raised now waits through the whole boot.
        held_data = mem_data_t'(take_bits(16));
        @(posedge i_clk);
        host_request(1'b1, HELD_ADDR, held_data, 1);
        check_value("host request held cycles nonzero", 1, held_cycles > 0);
        check_value("o_is_booted", 1, o_is_booted);

        check_value("first period byte count", 3, first_bytes.size());
        if (first_bytes.size() >= 3) begin
            check_value("eeprom command", SPI_CMD_READ, first_bytes[0]);
            check_value("eeprom addr hi", BOOT_SRC_ADDR[15:8], first_bytes[1]);
            check_value("eeprom addr lo", BOOT_SRC_ADDR[7:0], first_bytes[2]);
        end
        check_value("chip select periods", 1, cs_periods);
        finish_test(2, "eeprom read header");

        // Let the last boot write land.
        repeat (2) @(negedge i_clk);
        for (int w = 0; w < BOOT_WORDS; w++) begin
            check_value($sformatf("sram[%h]", BOOT_BASE + w),
                        {eeprom_img[8'(BOOT_SRC_ADDR + 2 * w)],
                         eeprom_img[8'(BOOT_SRC_ADDR + 2 * w + 1)]},
                        sram[BOOT_BASE + w]);
        end
        check_value("boot write count", BOOT_WORDS, boot_writes);
        check_value("boot writes outside image", 0, bad_boot_addr);
        finish_test(3, "boot image copy");

        // Read back the held write.
        @(posedge i_clk);
        host_request(1'b0, HELD_ADDR, '0, 1);
        wait_reads_done();
        check_value("host ready before boot", 0, ready_early);
        finish_test(4, "host request held during boot");

        // Small window so reads often hit earlier writes.
        @(posedge i_clk);
        for (int n = 0; n < RAND_TXNS; n++) begin
            wr_bit = 1'(take_bits(1));
            addr   = RAND_BASE | mem_addr_t'(take_bits(6));
            data   = mem_data_t'(take_bits(16));
            gap    = int'(take_bits(2));
            host_request(wr_bit, addr, data, gap);
        end
        i_host_valid <= 1'b0;
        wait_reads_done();
        finish_test(5, "random host traffic");

        repeat (4) @(negedge i_clk);
        check_value("spi activity after boot", 0, spi_after_boot);
        check_value("assertion failures", 0, i_uproc.i_uproc_properties.fail_count);
        finish_test(6, "storage idle after boot");

        $display("Summary: %0d tests, %0d passed, %0d with errors, %0d errors total",
                 tests_run, tests_run - tests_bad, tests_bad, error_count);
        if ((error_count == 0) && (tests_bad == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uproc.sv
`timescale 1ns/10ps
`default_nettype none

module uproc (
    // Clock and reset.
    input  logic               i_clk,
    input  logic               i_rst_n,

    // SRAM.
    output mem_pkg::mem_addr_t o_mem_addr,
    output mem_pkg::mem_data_t o_mem_wdata,
    input  mem_pkg::mem_data_t i_mem_rdata,
    output logic               o_mem_wr,
    output logic               o_mem_en,

    // EEPROM over SPI.
    output logic               o_store_sck,
    output logic               o_store_sdi,
    input  logic               i_store_sdo,
    output logic               o_store_scs_n,

    // Host access port, stands in for debug and core masters.
    input  logic               i_host_valid,
    output logic               o_host_ready,
    input  logic               i_host_wr,
    input  mem_pkg::mem_addr_t i_host_addr,
    input  mem_pkg::mem_data_t i_host_wdata,
    output mem_pkg::mem_data_t o_host_rdata,
    output logic               o_host_rvalid,

    // Status.
    output logic               o_is_booted
);

    // Boot status, also selects the SRAM bus owner.
    logic is_booted;

    // One request channel per SRAM requester, one byte channel to SPI.
    mem_bus_if  boot_bus ();
    mem_bus_if  host_bus ();
    spi_xfer_if spi_bus ();

    // ------------------------------
    // Host port onto its channel
    // ------------------------------

    assign host_bus.req_valid = i_host_valid;
    assign host_bus.req_wr    = i_host_wr;
    assign host_bus.req_addr  = i_host_addr;
    assign host_bus.req_wdata = i_host_wdata;
    assign o_host_ready       = host_bus.req_ready;
    assign o_is_booted        = is_booted;

    // ------------------------------
    // Blocks
    // ------------------------------

    // Copies the image, then hands the bus to the host.
    boot_block i_boot_block (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .mem         (boot_bus.master),
        .spi         (spi_bus.master),
        .o_is_booted (is_booted)
    );

    storage_ctrl i_storage_ctrl (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .spi     (spi_bus.slave),
        .o_sck   (o_store_sck),
        .o_sdi   (o_store_sdi),
        .i_sdo   (i_store_sdo),
        .o_scs_n (o_store_scs_n)
    );

    memory_ctrl i_memory_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_is_booted   (is_booted),
        .boot          (boot_bus.arbiter),
        .host          (host_bus.arbiter),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wdata   (o_mem_wdata),
        .i_mem_rdata   (i_mem_rdata),
        .o_mem_wr      (o_mem_wr),
        .o_mem_en      (o_mem_en),
        .o_host_rdata  (o_host_rdata),
        .o_host_rvalid (o_host_rvalid)
    );

endmodule

`default_nettype wire

//--- uproc_properties.sv
`timescale 1ns/10ps
`default_nettype none

module uproc_properties (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic o_mem_wr,
    input  logic o_mem_en,
    input  logic o_store_sck,
    input  logic o_store_scs_n,
    input  logic o_host_ready,
    input  logic o_host_rvalid,
    input  logic o_is_booted
);

    // Count of failed assertions.
    int fail_count = 0;

    // A write strobe is only valid inside an enabled bus cycle.
    a_wr_has_en: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mem_wr |-> o_mem_en)
        else begin
            fail_count++;
            $error("SRAM write strobe high without enable");
        end

    // Mode 0 idles SCK low while the EEPROM is deselected.
    a_sck_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_store_scs_n |-> !o_store_sck)
        else begin
            fail_count++;
            $error("SPI clock active with chip select released");
        end

    // Booted is sticky until reset.
    a_booted_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_is_booted |=> o_is_booted)
        else begin
            fail_count++;
            $error("Booted status dropped");
        end

    // No host traffic before the image is in place.
    a_host_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_is_booted |-> (!o_host_ready && !o_host_rvalid))
        else begin
            fail_count++;
            $error("Host port active before boot");
        end

endmodule

bind uproc uproc_properties i_uproc_properties (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .o_mem_wr      (o_mem_wr),
    .o_mem_en      (o_mem_en),
    .o_store_sck   (o_store_sck),
    .o_store_scs_n (o_store_scs_n),
    .o_host_ready  (o_host_ready),
    .o_host_rvalid (o_host_rvalid),
    .o_is_booted   (o_is_booted)
);

`default_nettype wire
